//--- SignalTimestamper.f
+incdir+include
hw/timestamper_pkg.sv
hw/EventDetector.sv
hw/DelayCompensator.sv
hw/AxiLiteAccess.sv
hw/TimestampRegisters.sv
hw/SignalTimestamper.sv
verif/SignalTimestamper_checker.sv
verif/SignalTimestamper_tb.sv

//--- hw/AxiLiteAccess.sv
// AXI4-Lite register access
`timescale 1ns/100ps

module AxiLiteAccess (
  input  logic                       SysClk_ClkIn,
  input  logic                       SysRstN_RstIn,
  input  timestamper_pkg::AxiWrReqT  AxiWrReq,
  output timestamper_pkg::AxiWrRspT  AxiWrRsp,
  input  timestamper_pkg::AxiRdReqT  AxiRdReq,
  output timestamper_pkg::AxiRdRspT  AxiRdRsp,
  output timestamper_pkg::RegAccessT RegAccess,
  input  timestamper_pkg::RegReplyT  RegReply
);

  typedef enum logic [1:0] {
    Idle,
    Write,
    Read,
    Resp
  } StateT;

  StateT                    state;
  logic                     awReady;
  logic                     wReady;
  logic                     arReady;
  logic                     bValid;
  logic                     rValid;
  timestamper_pkg::AxiRespT bResp;
  timestamper_pkg::AxiRespT rResp;
  logic [$bits(RegReply.rdData)-1:0] rData;
  logic                     wrFire;
  logic                     rdFire;
  timestamper_pkg::AxiRespT accessResp;

  assign wrFire = (state == Write) && AxiWrReq.awValid && awReady &&
                  AxiWrReq.wValid && wReady;
  assign rdFire = (state == Read) && AxiRdReq.arValid && arReady;

  assign accessResp = RegReply.hit ? timestamper_pkg::Okay : timestamper_pkg::SlvErr;

  // single strobe in the transfer cycle
  assign RegAccess = '{wrEn:   wrFire,
                       rdEn:   rdFire,
                       addr:   (state == Write) ? AxiWrReq.awAddr : AxiRdReq.arAddr,
                       wrData: AxiWrReq.wData};

  // ******************************
  // handshake FSM
  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      state   <= Idle;
      awReady <= 1'b0;
      wReady  <= 1'b0;
      arReady <= 1'b0;
      bValid  <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          // writes win over reads
          if (AxiWrReq.awValid && AxiWrReq.wValid) begin
            awReady <= 1'b1;
            wReady  <= 1'b1;
            state   <= Write;
          end else if (AxiRdReq.arValid) begin
            arReady <= 1'b1;
            state   <= Read;
          end
        end
        Write: begin
          if (wrFire) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b1;
            state   <= Resp;
          end
        end
        Read: begin
          if (rdFire) begin
            arReady <= 1'b0;
            rValid  <= 1'b1;
            state   <= Resp;
          end
        end
        default: begin
          if ((bValid && AxiWrReq.bReady) || (rValid && AxiRdReq.rReady)) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
            state  <= Idle;
          end
        end
      endcase
    end
  end

  // response payload held until accepted
  always_ff @(posedge SysClk_ClkIn) begin
    if (wrFire) begin
      bResp <= accessResp;
    end
    if (rdFire) begin
      rResp <= accessResp;
      rData <= RegReply.rdData;
    end
  end

  assign AxiWrRsp = '{awReady: awReady, wReady: wReady, bValid: bValid, bResp: bResp};
  assign AxiRdRsp = '{arReady: arReady, rValid: rValid, rResp: rResp, rData: rData};

endmodule

//--- hw/DelayCompensator.sv
// Timestamp delay compensation
`timescale 1ns/100ps
`include "timestamper_settings.svh"

module DelayCompensator (
  input  logic                       SysClk_ClkIn,
  input  logic                       SysRstN_RstIn,
  input  logic                       Event,
  input  timestamper_pkg::ClockTimeT ClockTime,
  input  logic [15:0]                CableDelay,
  output timestamper_pkg::TimestampT Timestamp
);

  localparam int NsWidth = `TS_NANOSECOND_WIDTH;
  // input path plus synchronizer latency
  localparam logic [NsWidth-1:0] FixedDelayNs =
    `TS_INPUT_DELAY_NS + `TS_SYNC_DELAY_CYCLES * `TS_CLOCK_PERIOD_NS;

  timestamper_pkg::TaiTimeT capturedTime;
  logic [NsWidth-1:0]       totalDelay;
  logic                     capturePending;
  logic                     borrow;
  timestamper_pkg::TaiTimeT tsTai;
  logic                     tsValid;

  // ******************************
  // stage 1, latch time and delay at the event
  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      capturePending <= 1'b0;
      tsValid        <= 1'b0;
    end else begin
      // an invalid clock time gives no timestamp at all
      capturePending <= Event & ClockTime.valid;
      tsValid        <= capturePending;
    end
  end

  always_ff @(posedge SysClk_ClkIn) begin
    if (Event) begin
      capturedTime <= ClockTime.tai;
      totalDelay   <= FixedDelayNs + {{(NsWidth - 16){1'b0}}, CableDelay};
    end
  end

  // ******************************
  // stage 2, subtract with borrow
  assign borrow = capturedTime.nanosecond < totalDelay;

  always_ff @(posedge SysClk_ClkIn) begin
    if (capturePending) begin
      if (borrow) begin
        tsTai.nanosecond <= capturedTime.nanosecond + `TS_SECOND_NANOSECONDS - totalDelay;
        tsTai.second     <= capturedTime.second - 1'b1;
      end else begin
        tsTai.nanosecond <= capturedTime.nanosecond - totalDelay;
        tsTai.second     <= capturedTime.second;
      end
    end
  end

  assign Timestamp = '{tai: tsTai, valid: tsValid};

endmodule

//--- hw/EventDetector.sv
// Input edge detector
`timescale 1ns/100ps

module EventDetector (
  input  logic SysClk_ClkIn,
  input  logic SysRstN_RstIn,
  input  logic Polarity,
  input  logic SignalIn,
  output logic Event
);

  logic       activeLevel;
  logic [1:0] syncQ;
  logic       lastLevel;

  // polarity applied ahead of the synchronizer, so only active-high travels on
  assign activeLevel = Polarity ? SignalIn : ~SignalIn;

  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      syncQ     <= 2'b00;
      lastLevel <= 1'b0;
    end else begin
      syncQ     <= {syncQ[0], activeLevel};
      lastLevel <= syncQ[1];
    end
  end

  // rising edge of the synchronized level
  assign Event = syncQ[1] & ~lastLevel;

endmodule

//--- hw/SignalTimestamper.sv
// Signal timestamper top level
`timescale 1ns/100ps

module SignalTimestamper (
  input  logic                      SysClk_ClkIn,
  input  logic                      SysRstN_RstIn,
  input  timestamper_pkg::ClockTimeT ClockTime,
  input  logic                      SignalIn,
  input  timestamper_pkg::AxiWrReqT AxiWrReq,
  output timestamper_pkg::AxiWrRspT AxiWrRsp,
  input  timestamper_pkg::AxiRdReqT AxiRdReq,
  output timestamper_pkg::AxiRdRspT AxiRdRsp,
  output logic                      Irq
);

  timestamper_pkg::TsConfigT  tsConfig;
  timestamper_pkg::TimestampT timestamp;
  timestamper_pkg::RegAccessT regAccess;
  timestamper_pkg::RegReplyT  regReply;
  logic                       signalEvent;

  EventDetector eventDetector0 (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .Polarity      (tsConfig.polarity),
    .SignalIn      (SignalIn),
    .Event         (signalEvent)
  );

  DelayCompensator delayCompensator0 (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .Event         (signalEvent),
    .ClockTime     (ClockTime),
    .CableDelay    (tsConfig.cableDelay),
    .Timestamp     (timestamp)
  );

  AxiLiteAccess axiLiteAccess0 (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .AxiWrReq      (AxiWrReq),
    .AxiWrRsp      (AxiWrRsp),
    .AxiRdReq      (AxiRdReq),
    .AxiRdRsp      (AxiRdRsp),
    .RegAccess     (regAccess),
    .RegReply      (regReply)
  );

  TimestampRegisters timestampRegisters0 (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .RegAccess     (regAccess),
    .RegReply      (regReply),
    .Timestamp     (timestamp),
    .Config        (tsConfig),
    .Irq           (Irq)
  );

endmodule

//--- hw/TimestampRegisters.sv
// Timestamper register file
`timescale 1ns/100ps
`include "timestamper_settings.svh"

module TimestampRegisters (
  input  logic                       SysClk_ClkIn,
  input  logic                       SysRstN_RstIn,
  input  timestamper_pkg::RegAccessT RegAccess,
  output timestamper_pkg::RegReplyT  RegReply,
  input  timestamper_pkg::TimestampT Timestamp,
  output timestamper_pkg::TsConfigT  Config,
  output logic                       Irq
);

  localparam int DataWidth = `TS_DATA_WIDTH;

  logic [DataWidth-1:0] controlReg;
  logic [DataWidth-1:0] polarityReg;
  logic [DataWidth-1:0] cableDelayReg;
  logic [DataWidth-1:0] irqMaskReg;
  logic                 dropBit;
  logic                 irqBit;
  logic [DataWidth-1:0] evtCount;
  logic [DataWidth-1:0] capturedCount;
  logic [DataWidth-1:0] timeLow;
  logic [DataWidth-1:0] timeHigh;
  logic [DataWidth-1:0] rdData;
  logic                 mapped;
  logic                 readOnly;
  logic                 wrOk;

  // ******************************
  // read decode
  always_comb begin
    rdData = '0;
    mapped = 1'b1;
    case (RegAccess.addr)
      `TS_REG_CONTROL:     rdData = controlReg;
      `TS_REG_STATUS:      rdData = {{(DataWidth - 1){1'b0}}, dropBit};
      `TS_REG_POLARITY:    rdData = polarityReg;
      `TS_REG_VERSION:     rdData = `TS_VERSION;
      `TS_REG_CABLE_DELAY: rdData = cableDelayReg;
      `TS_REG_IRQ:         rdData = {{(DataWidth - 1){1'b0}}, irqBit};
      `TS_REG_IRQ_MASK:    rdData = irqMaskReg;
      `TS_REG_EVT_COUNT:   rdData = evtCount;
      `TS_REG_COUNT:       rdData = capturedCount;
      `TS_REG_TIME_L:      rdData = timeLow;
      `TS_REG_TIME_H:      rdData = timeHigh;
      default:             mapped = 1'b0;
    endcase
  end

  assign readOnly = RegAccess.addr inside {`TS_REG_VERSION, `TS_REG_EVT_COUNT,
                                           `TS_REG_COUNT, `TS_REG_TIME_L, `TS_REG_TIME_H};
  assign wrOk     = RegAccess.wrEn & mapped & ~readOnly;

  assign RegReply = '{rdData: rdData,
                      hit:    mapped & (RegAccess.rdEn | (RegAccess.wrEn & ~readOnly))};

  // ******************************
  // register update and capture
  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      controlReg    <= '0;
      polarityReg   <= {{(DataWidth - 1){1'b0}}, `TS_DEFAULT_POLARITY};
      cableDelayReg <= '0;
      irqMaskReg    <= '0;
      dropBit       <= 1'b0;
      irqBit        <= 1'b0;
      evtCount      <= '0;
      capturedCount <= '0;
      timeLow       <= '0;
      timeHigh      <= '0;
    end else begin
      if (wrOk) begin
        case (RegAccess.addr)
          `TS_REG_CONTROL:     controlReg    <= RegAccess.wrData & `TS_MASK_CONTROL;
          `TS_REG_POLARITY:    polarityReg   <= RegAccess.wrData & `TS_MASK_POLARITY;
          `TS_REG_CABLE_DELAY: cableDelayReg <= RegAccess.wrData & `TS_MASK_CABLE_DELAY;
          `TS_REG_IRQ_MASK:    irqMaskReg    <= RegAccess.wrData & `TS_MASK_IRQ_MASK;
          // write one to clear
          `TS_REG_STATUS: begin
            if (|(RegAccess.wrData & `TS_MASK_STATUS)) dropBit <= 1'b0;
          end
          `TS_REG_IRQ: begin
            if (|(RegAccess.wrData & `TS_MASK_IRQ)) irqBit <= 1'b0;
          end
          default: begin
          end
        endcase
      end
      if (Config.enable) begin
        if (Timestamp.valid) begin
          evtCount <= evtCount + 1'b1;
          if (!irqBit) begin
            irqBit        <= 1'b1;
            capturedCount <= evtCount + 1'b1;
            timeLow       <= Timestamp.tai.nanosecond;
            timeHigh      <= Timestamp.tai.second;
          end else begin
            // previous timestamp still unread, sticky drop
            dropBit <= 1'b1;
          end
        end
      end else begin
        evtCount      <= '0;
        capturedCount <= '0;
        irqBit        <= 1'b0;
        dropBit       <= 1'b0;
      end
    end
  end

  assign Config = '{enable:     controlReg[0],
                    polarity:   polarityReg[0],
                    cableDelay: cableDelayReg[15:0]};

  assign Irq = irqBit & irqMaskReg[0];

endmodule

//--- hw/timestamper_pkg.sv
// Timestamper shared types
`include "timestamper_settings.svh"

package timestamper_pkg;

  typedef struct packed {
    logic [`TS_SECOND_WIDTH-1:0]     second;
    logic [`TS_NANOSECOND_WIDTH-1:0] nanosecond;
  } TaiTimeT;

  typedef struct packed {
    TaiTimeT tai;
    logic    valid;
  } ClockTimeT;

  // valid is a single-cycle pulse
  typedef struct packed {
    TaiTimeT tai;
    logic    valid;
  } TimestampT;

  typedef struct packed {
    logic        enable;
    logic        polarity;
    logic [15:0] cableDelay;
  } TsConfigT;

  // ******************************
  // AXI4-Lite channels
  typedef enum logic [1:0] {
    Okay   = 2'b00,
    SlvErr = 2'b10
  } AxiRespT;

  typedef struct packed {
    logic                     awValid;
    logic [`TS_ADDR_WIDTH-1:0] awAddr;
    logic                     wValid;
    logic [`TS_DATA_WIDTH-1:0] wData;
    logic                     bReady;
  } AxiWrReqT;

  typedef struct packed {
    logic    awReady;
    logic    wReady;
    logic    bValid;
    AxiRespT bResp;
  } AxiWrRspT;

  typedef struct packed {
    logic                     arValid;
    logic [`TS_ADDR_WIDTH-1:0] arAddr;
    logic                     rReady;
  } AxiRdReqT;

  typedef struct packed {
    logic                     arReady;
    logic                     rValid;
    AxiRespT                  rResp;
    logic [`TS_DATA_WIDTH-1:0] rData;
  } AxiRdRspT;

  // one register access per accepted transfer
  typedef struct packed {
    logic                     wrEn;
    logic                     rdEn;
    logic [`TS_ADDR_WIDTH-1:0] addr;
    logic [`TS_DATA_WIDTH-1:0] wrData;
  } RegAccessT;

  typedef struct packed {
    logic [`TS_DATA_WIDTH-1:0] rdData;
    logic                     hit;
  } RegReplyT;

endpackage

//--- include/timestamper_settings.svh
// Timestamper settings
`ifndef TIMESTAMPER_SETTINGS_SVH
`define TIMESTAMPER_SETTINGS_SVH

// ******************************
// time base and delays
`define TS_CLOCK_PERIOD_NS     32'd10
`define TS_INPUT_DELAY_NS      32'd100
`define TS_SYNC_DELAY_CYCLES   2
`define TS_SECOND_NANOSECONDS  32'd1_000_000_000
`define TS_SECOND_WIDTH        32
`define TS_NANOSECOND_WIDTH    32

// ******************************
// register map
`define TS_ADDR_WIDTH          16
`define TS_DATA_WIDTH          32
`define TS_REG_CONTROL         16'h0000
`define TS_REG_STATUS          16'h0004
`define TS_REG_POLARITY        16'h0008
`define TS_REG_VERSION         16'h000C
`define TS_REG_CABLE_DELAY     16'h0020
`define TS_REG_IRQ             16'h0030
`define TS_REG_IRQ_MASK        16'h0034
`define TS_REG_EVT_COUNT       16'h0038
`define TS_REG_COUNT           16'h0040
`define TS_REG_TIME_L          16'h0044
`define TS_REG_TIME_H          16'h0048

// writable bits per register
`define TS_MASK_CONTROL        32'h0000_0001
`define TS_MASK_STATUS         32'h0000_0001
`define TS_MASK_POLARITY       32'h0000_0001
`define TS_MASK_CABLE_DELAY    32'h0000_FFFF
`define TS_MASK_IRQ            32'h0000_0001
`define TS_MASK_IRQ_MASK       32'h0000_0001

`define TS_VERSION             32'h0001_0000
`define TS_DEFAULT_POLARITY    1'b1

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the timestamper testbench with Verilator
verilator --binary --assert -Wno-fatal --top-module SignalTimestamper_tb \
  -f SignalTimestamper.f -o SignalTimestamper_sim > build.log 2>&1 &&
  ./obj_dir/SignalTimestamper_sim > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Finished with errors" sim.log &&
  { echo "simulation reported errors, see sim.log"; exit 1; }
echo "simulation passed"

//--- verif/SignalTimestamper_checker.sv
// Timestamper bus and interrupt checks
`timescale 1ns/100ps

module SignalTimestamper_checker (
  input logic                      SysClk_ClkIn,
  input logic                      SysRstN_RstIn,
  input timestamper_pkg::AxiWrReqT AxiWrReq,
  input timestamper_pkg::AxiWrRspT AxiWrRsp,
  input timestamper_pkg::AxiRdReqT AxiRdReq,
  input timestamper_pkg::AxiRdRspT AxiRdRsp,
  input logic                      Irq,
  input logic                      TsValid,
  input logic                      RegWrite
);

  // write response held until bReady
  bRespHeld: assert property (@(posedge SysClk_ClkIn) disable iff (SysRstN_RstIn)
    AxiWrRsp.bValid && !AxiWrReq.bReady |=> AxiWrRsp.bValid && $stable(AxiWrRsp.bResp))
    else $error("bValid or bResp changed before bReady");

  // read response and data held until rReady
  rRespHeld: assert property (@(posedge SysClk_ClkIn) disable iff (SysRstN_RstIn)
    AxiRdRsp.rValid && !AxiRdReq.rReady |=>
      AxiRdRsp.rValid && $stable(AxiRdRsp.rResp) && $stable(AxiRdRsp.rData))
    else $error("rValid, rResp or rData changed before rReady");

  // one access in flight
  readyExclusive: assert property (@(posedge SysClk_ClkIn) disable iff (SysRstN_RstIn)
    !(AxiWrRsp.awReady && AxiRdRsp.arReady))
    else $error("awReady and arReady high together");

  // Irq only rises after a timestamp pulse or a register write
  irqSource: assert property (@(posedge SysClk_ClkIn) disable iff (SysRstN_RstIn)
    $rose(Irq) |-> $past(TsValid) || $past(RegWrite))
    else $error("Irq rose without a timestamp pulse or a register write");

endmodule

bind AxiLiteAccess SignalTimestamper_checker busChecker0 (
  .SysClk_ClkIn  (SysClk_ClkIn),
  .SysRstN_RstIn (SysRstN_RstIn),
  .AxiWrReq      (AxiWrReq),
  .AxiWrRsp      (AxiWrRsp),
  .AxiRdReq      (AxiRdReq),
  .AxiRdRsp      (AxiRdRsp),
  .Irq           (1'b0),
  .TsValid       (1'b0),
  .RegWrite      (1'b0)
);

bind TimestampRegisters SignalTimestamper_checker irqChecker0 (
  .SysClk_ClkIn  (SysClk_ClkIn),
  .SysRstN_RstIn (SysRstN_RstIn),
  .AxiWrReq      ('0),
  .AxiWrRsp      ('0),
  .AxiRdReq      ('0),
  .AxiRdRsp      ('0),
  .Irq           (Irq),
  .TsValid       (Timestamp.valid),
  .RegWrite      (wrOk)
);

//--- verif/SignalTimestamper_tb.sv
// Signal timestamper testbench
`timescale 1ns/100ps
`include "timestamper_settings.svh"

module SignalTimestamper_tb;

  // headroom over the traffic below at full back-pressure
  localparam int CycleLimit = 4000;
  // just short of a second rollover
  localparam timestamper_pkg::ClockTimeT StartTime =
    '{tai: '{second: 32'd5, nanosecond: 32'd999_999_900}, valid: 1'b1};

  logic                       SysClk_ClkIn = 1'b0;
  logic                       SysRstN_RstIn;
  timestamper_pkg::ClockTimeT clockTime = StartTime;
  logic                       signalIn;
  timestamper_pkg::AxiWrReqT  wrReq;
  timestamper_pkg::AxiWrRspT  wrRsp;
  timestamper_pkg::AxiRdReqT  rdReq;
  timestamper_pkg::AxiRdRspT  rdRsp;
  logic                       irq;
  logic [31:0]                lfsrState = 32'h3641_c90d;
  int                         cycleCount = 0;
  int                         dataErrors = 0;
  int                         respErrors = 0;
  int                         irqErrors = 0;
  int                         expEvtCount = 0;

  SignalTimestamper dut0 (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .ClockTime     (clockTime),
    .SignalIn      (signalIn),
    .AxiWrReq      (wrReq),
    .AxiWrRsp      (wrRsp),
    .AxiRdReq      (rdReq),
    .AxiRdRsp      (rdRsp),
    .Irq           (irq)
  );

  always #(`TS_CLOCK_PERIOD_NS / 2) SysClk_ClkIn = ~SysClk_ClkIn;

  // free-running TAI time, one clock period per cycle
  always @(posedge SysClk_ClkIn) begin
    if (clockTime.tai.nanosecond >= `TS_SECOND_NANOSECONDS - `TS_CLOCK_PERIOD_NS) begin
      clockTime.tai.nanosecond <= clockTime.tai.nanosecond + `TS_CLOCK_PERIOD_NS
                                  - `TS_SECOND_NANOSECONDS;
      clockTime.tai.second     <= clockTime.tai.second + 32'd1;
    end else begin
      clockTime.tai.nanosecond <= clockTime.tai.nanosecond + `TS_CLOCK_PERIOD_NS;
    end
  end

  always @(posedge SysClk_ClkIn) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ******************************
  // stimulus helpers

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic randomBits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  // time at the first sampling edge less input and cable delay
  function automatic timestamper_pkg::TaiTimeT expectTimestamp(
    input timestamper_pkg::TaiTimeT edgeTime, input logic [15:0] cableDelay);
    timestamper_pkg::TaiTimeT result;
    logic [31:0]              delay;
    delay = `TS_INPUT_DELAY_NS + {16'h0, cableDelay};
    if (edgeTime.nanosecond < delay) begin
      result.nanosecond = edgeTime.nanosecond + `TS_SECOND_NANOSECONDS - delay;
      result.second     = edgeTime.second - 32'd1;
    end else begin
      result.nanosecond = edgeTime.nanosecond - delay;
      result.second     = edgeTime.second;
    end
    return result;
  endfunction

  task automatic checkData(input string name, input logic [`TS_DATA_WIDTH-1:0] got,
                           input logic [`TS_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      dataErrors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkResp(input string name, input timestamper_pkg::AxiRespT got,
                           input timestamper_pkg::AxiRespT exp);
    if (got !== exp) begin
      respErrors++;
      $display("Error at %0t ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic checkIrq(input logic exp);
    if (irq !== exp) begin
      irqErrors++;
      $display("Error at %0t ns: Irq is %b, expected %b", $time, irq, exp);
    end
  endtask

  task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
                          output timestamper_pkg::AxiRespT resp);
    logic [31:0] delay;
    @(posedge SysClk_ClkIn);
    wrReq.awValid <= 1'b1;
    wrReq.awAddr  <= addr;
    wrReq.wValid  <= 1'b1;
    wrReq.wData   <= data;
    do @(posedge SysClk_ClkIn); while (!(wrRsp.awReady && wrRsp.wReady));
    wrReq.awValid <= 1'b0;
    wrReq.wValid  <= 1'b0;
    randomBits(3, delay);
    repeat (delay) @(posedge SysClk_ClkIn);
    wrReq.bReady <= 1'b1;
    do @(posedge SysClk_ClkIn); while (!wrRsp.bValid);
    resp = wrRsp.bResp;
    wrReq.bReady <= 1'b0;
  endtask

  task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
                         output timestamper_pkg::AxiRespT resp);
    logic [31:0] delay;
    @(posedge SysClk_ClkIn);
    rdReq.arValid <= 1'b1;
    rdReq.arAddr  <= addr;
    do @(posedge SysClk_ClkIn); while (!rdRsp.arReady);
    rdReq.arValid <= 1'b0;
    randomBits(3, delay);
    repeat (delay) @(posedge SysClk_ClkIn);
    rdReq.rReady <= 1'b1;
    do @(posedge SysClk_ClkIn); while (!rdRsp.rValid);
    resp = rdRsp.rResp;
    data = rdRsp.rData;
    rdReq.rReady <= 1'b0;
  endtask

  task automatic writeReg(input logic [15:0] addr, input logic [31:0] data);
    timestamper_pkg::AxiRespT resp;
    axiWrite(addr, data, resp);
    checkResp("bResp", resp, timestamper_pkg::Okay);
  endtask

  task automatic expectReg(input logic [15:0] addr, input logic [31:0] exp,
                           input string name);
    timestamper_pkg::AxiRespT resp;
    logic [31:0]              data;
    axiRead(addr, data, resp);
    checkResp("rResp", resp, timestamper_pkg::Okay);
    checkData(name, data, exp);
  endtask

  // poll until bit 0 of the register is set
  task automatic waitRegBit(input logic [15:0] addr);
    timestamper_pkg::AxiRespT resp;
    logic [31:0]              data;
    data = '0;
    while (!data[0]) begin
      axiRead(addr, data, resp);
    end
  endtask

  task automatic fireEvent(input logic activeLevel,
                           output timestamper_pkg::TaiTimeT edgeTime);
    logic [31:0] gap;
    @(posedge SysClk_ClkIn);
    signalIn <= activeLevel;
    // first edge that samples the active level
    @(posedge SysClk_ClkIn);
    edgeTime = clockTime.tai;
    repeat (4) @(posedge SysClk_ClkIn);
    signalIn <= ~activeLevel;
    randomBits(4, gap);
    repeat (gap + 3) @(posedge SysClk_ClkIn);
  endtask

  // one captured event, then the interrupt is cleared
  task automatic timestampRound(input logic activeLevel, input logic [15:0] cableDelay);
    timestamper_pkg::TaiTimeT edgeTime;
    timestamper_pkg::TaiTimeT expTime;
    writeReg(`TS_REG_CABLE_DELAY, {16'h0, cableDelay});
    fireEvent(activeLevel, edgeTime);
    expEvtCount++;
    waitRegBit(`TS_REG_IRQ);
    expTime = expectTimestamp(edgeTime, cableDelay);
    expectReg(`TS_REG_TIME_H, expTime.second, "timeHigh");
    expectReg(`TS_REG_TIME_L, expTime.nanosecond, "timeLow");
    expectReg(`TS_REG_COUNT, expEvtCount, "capturedCount");
    expectReg(`TS_REG_EVT_COUNT, expEvtCount, "evtCount");
    writeReg(`TS_REG_IRQ, 32'h1);
  endtask

  // ******************************
  // test sequence
  initial begin
    timestamper_pkg::AxiRespT resp;
    timestamper_pkg::TaiTimeT firstTime;
    timestamper_pkg::TaiTimeT droppedTime;
    timestamper_pkg::TaiTimeT expTime;
    logic [31:0]              data;
    logic [31:0]              cable;
    SysRstN_RstIn = 1'b1;
    signalIn      = 1'b0;
    wrReq         = '0;
    rdReq         = '0;
    repeat (3) @(posedge SysClk_ClkIn);
    SysRstN_RstIn <= 1'b0;

    // reset values and decode errors
    expectReg(`TS_REG_VERSION, `TS_VERSION, "version");
    expectReg(`TS_REG_POLARITY, {31'h0, `TS_DEFAULT_POLARITY}, "polarity");
    expectReg(`TS_REG_CONTROL, 32'h0, "control");
    expectReg(`TS_REG_IRQ, 32'h0, "irq");
    expectReg(`TS_REG_EVT_COUNT, 32'h0, "evtCount");
    expectReg(`TS_REG_COUNT, 32'h0, "capturedCount");
    checkIrq(1'b0);
    axiRead(16'h0010, data, resp);
    checkResp("rResp unmapped", resp, timestamper_pkg::SlvErr);
    axiWrite(`TS_REG_VERSION, 32'hFFFF_FFFF, resp);
    checkResp("bResp read-only", resp, timestamper_pkg::SlvErr);

    // first event lands just after the rollover, so the large delay borrows a second
    writeReg(`TS_REG_CONTROL, 32'h1);
    randomBits(16, cable);
    timestampRound(1'b1, cable[15:0] | 16'h0800);
    repeat (3) begin
      randomBits(16, cable);
      timestampRound(1'b1, cable[15:0]);
    end

    // masked interrupt output
    writeReg(`TS_REG_IRQ_MASK, 32'h1);
    fireEvent(1'b1, firstTime);
    expEvtCount++;
    checkIrq(1'b1);
    writeReg(`TS_REG_IRQ, 32'h1);
    checkIrq(1'b0);
    writeReg(`TS_REG_IRQ_MASK, 32'h0);
    fireEvent(1'b1, firstTime);
    expEvtCount++;
    waitRegBit(`TS_REG_IRQ);
    checkIrq(1'b0);

    // second event with the interrupt still pending
    fireEvent(1'b1, droppedTime);
    expEvtCount++;
    waitRegBit(`TS_REG_STATUS);
    expTime = expectTimestamp(firstTime, cable[15:0]);
    expectReg(`TS_REG_TIME_H, expTime.second, "timeHigh");
    expectReg(`TS_REG_TIME_L, expTime.nanosecond, "timeLow");
    expectReg(`TS_REG_COUNT, expEvtCount - 1, "capturedCount");
    expectReg(`TS_REG_EVT_COUNT, expEvtCount, "evtCount");

    // disable clears state and ignores the input
    writeReg(`TS_REG_CONTROL, 32'h0);
    expEvtCount = 0;
    expectReg(`TS_REG_EVT_COUNT, 32'h0, "evtCount");
    expectReg(`TS_REG_COUNT, 32'h0, "capturedCount");
    expectReg(`TS_REG_STATUS, 32'h0, "status");
    expectReg(`TS_REG_IRQ, 32'h0, "irq");
    @(posedge SysClk_ClkIn);
    signalIn <= 1'b1;
    repeat (8) @(posedge SysClk_ClkIn);
    expectReg(`TS_REG_EVT_COUNT, 32'h0, "evtCount");
    expectReg(`TS_REG_IRQ, 32'h0, "irq");

    // falling-edge events with the input idling high
    writeReg(`TS_REG_POLARITY, 32'h0);
    writeReg(`TS_REG_CONTROL, 32'h1);
    randomBits(16, cable);
    timestampRound(1'b0, cable[15:0]);

    $display("Error count: data %0d, response %0d, irq %0d",
             dataErrors, respErrors, irqErrors);
    if (dataErrors + respErrors + irqErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
